// File: include/draw_params.svh
`ifndef DRAW_PARAMS_SVH
`define DRAW_PARAMS_SVH

// screen geometry.
`define DRAW_SCREEN_W 160
`define DRAW_SCREEN_H 120

// pixel FIFO between producer and writer.
`define DRAW_FIFO_DEPTH 8

// coordinate and colour widths.
`define DRAW_X_W 8
`define DRAW_Y_W 7
`define DRAW_C_W 3

`endif

// File: src/draw_pkg.sv
`include "draw_params.svh"

package draw_pkg;

	typedef struct packed {
		logic [`DRAW_X_W-1:0] x;
		logic [`DRAW_Y_W-1:0] y;
		logic [`DRAW_C_W-1:0] colour;
	} pixel_t;

	// end of shape, same width as a pixel.
	typedef struct packed {
		logic [`DRAW_X_W+`DRAW_Y_W+`DRAW_C_W-1:0] count;
	} marker_t;

	typedef union packed {
		pixel_t  pixel;
		marker_t marker;
	} payload_u;

	typedef struct packed {
		logic     is_marker;          // selects the view of payload.
		payload_u payload;
	} fifo_entry_t;

	typedef struct packed {
		logic [`DRAW_X_W-1:0] x;
		logic [`DRAW_Y_W-1:0] y;
	} rd_port_t;

endpackage

// File: src/circle_engine.sv
`timescale 1ns/1ps
`include "draw_params.svh"

module circle_engine (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  logic             stall,
	input  draw_pkg::pixel_t centre,
	input  logic [7:0]       radius,
	output draw_pkg::pixel_t point,
	output logic             plot,
	output logic             done
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_RUN  = 2'd1;
	localparam logic [1:0] S_FIN  = 2'd2;
	localparam logic [1:0] S_WAIT = 2'd3;

	logic [1:0]          state;
	logic [2:0]          octant;
	logic [`DRAW_X_W-1:0] ox, oy, ox_next, oy_next;
	logic [`DRAW_X_W-1:0] dx, dy;
	logic signed [10:0]  crit, crit_next, diff;
	draw_pkg::pixel_t    ctr;

	// ------------------------------------------------------------
	// midpoint step, taken after the eighth reflection
	// ------------------------------------------------------------
	always_comb begin
		oy_next = oy + 1'b1;
		diff = '0;
		if (crit <= 0) begin
			ox_next = ox;
			crit_next = crit + $signed({2'b00, oy_next, 1'b1});  // + 2y + 1.
		end else begin
			ox_next = ox - 1'b1;
			diff = $signed({3'b000, oy_next}) - $signed({3'b000, ox_next});
			crit_next = crit + $signed({diff[9:0], 1'b1});       // + 2(y - x) + 1.
		end
	end

	// odd octants swap the offsets, the rest is sign selection.
	assign dx = octant[0] ? oy : ox;
	assign dy = octant[0] ? ox : oy;

	always_comb begin
		point.colour = ctr.colour;
		point.x = (octant[2] ^ octant[1]) ? ctr.x - dx : ctr.x + dx;
		point.y = octant[2] ? ctr.y - dy[`DRAW_Y_W-1:0] : ctr.y + dy[`DRAW_Y_W-1:0];
	end

	assign plot = (state == S_RUN) && !stall;
	assign done = (state == S_FIN);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			octant <= '0;
			ox <= '0;
			oy <= '0;
			crit <= '0;
		end else begin
			case (state)
				S_IDLE: if (start) begin
					state <= S_RUN;
					octant <= '0;
					ox <= radius;
					oy <= '0;
					crit <= 11'sd1 - $signed({3'b000, radius});
				end
				S_RUN: if (!start) begin
					state <= S_IDLE;              // aborted.
				end else if (!stall) begin
					octant <= octant + 1'b1;
					if (octant == 3'd7) begin
						ox <= ox_next;
						oy <= oy_next;
						crit <= crit_next;
						if (oy_next > ox_next)
							state <= S_FIN;       // past the diagonal.
					end
				end
				S_FIN: state <= S_WAIT;
				S_WAIT: if (!start) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && start)
			ctr <= centre;
	end

endmodule

// File: src/reuleaux_producer.sv
`timescale 1ns/1ps
`include "draw_params.svh"

module reuleaux_producer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [`DRAW_C_W-1:0]  colour,
	input  draw_pkg::pixel_t      centre,
	input  logic [7:0]            diameter,
	input  logic                  full,
	output logic                  push,
	output draw_pkg::fifo_entry_t entry
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_ARC1 = 3'd1;
	localparam logic [2:0] S_ARC2 = 3'd2;
	localparam logic [2:0] S_ARC3 = 3'd3;
	localparam logic [2:0] S_MARK = 3'd4;
	localparam logic [2:0] S_HOLD = 3'd5;

	logic [2:0]           state;
	logic                 gap;
	logic [17:0]          count;
	logic [13:0]          d37;
	logic [`DRAW_Y_W-1:0] top_rise, bot_drop, top_y, bot_y;
	logic [`DRAW_X_W-1:0] left_x, right_x;
	logic                 in_arc, in_mask, keep;
	logic                 eng_start, eng_plot, eng_done;
	draw_pkg::pixel_t     arc_centre, eng_point;

	// ------------------------------------------------------------
	// triangle vertices
	// ------------------------------------------------------------
	assign d37 = {6'd0, diameter} * 14'd37;
	assign top_rise = d37[12:6];
	assign bot_drop = d37[13:7];
	assign top_y = centre.y - top_rise;
	assign bot_y = centre.y + bot_drop;
	assign left_x = centre.x - {1'b0, diameter[7:1]};
	assign right_x = centre.x + {1'b0, diameter[7:1]};

	always_comb begin
		arc_centre.colour = colour;
		arc_centre.x = centre.x;
		arc_centre.y = top_y;
		case (state)
			S_ARC2: begin
				arc_centre.x = left_x;
				arc_centre.y = bot_y;
			end
			S_ARC3: begin
				arc_centre.x = right_x;
				arc_centre.y = bot_y;
			end
			default: ;
		endcase
	end

	assign in_arc = (state == S_ARC1) || (state == S_ARC2) || (state == S_ARC3);
	assign eng_start = in_arc && !gap;    // one low cycle between arcs.

	circle_engine u_engine (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (eng_start),
		.stall  (full),
		.centre (arc_centre),
		.radius (diameter),
		.point  (eng_point),
		.plot   (eng_plot),
		.done   (eng_done)
	);

	// region of the triangle each arc belongs to.
	always_comb begin
		case (state)
			S_ARC1: in_mask = eng_point.y > bot_y;
			S_ARC2: in_mask = (eng_point.x >= centre.x) && (eng_point.y <= bot_y);
			S_ARC3: in_mask = (eng_point.x < centre.x) && (eng_point.y <= bot_y);
			default: in_mask = 1'b0;
		endcase
	end

	assign keep = eng_plot && in_mask;

	always_comb begin
		push = 1'b0;
		entry = '0;
		if (in_arc) begin
			push = keep;
			entry.payload.pixel = eng_point;
		end else if (state == S_MARK) begin
			push = start && !full;
			entry.is_marker = 1'b1;
			entry.payload.marker.count = count;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			gap <= 1'b0;
			count <= '0;
		end else begin
			gap <= eng_done;
			if (keep)
				count <= count + 1'b1;
			case (state)
				S_IDLE: if (start) begin
					state <= S_ARC1;
					count <= '0;
				end
				S_ARC1: state <= !start ? S_IDLE : eng_done ? S_ARC2 : S_ARC1;
				S_ARC2: state <= !start ? S_IDLE : eng_done ? S_ARC3 : S_ARC2;
				S_ARC3: state <= !start ? S_IDLE : eng_done ? S_MARK : S_ARC3;
				S_MARK: state <= !start ? S_IDLE : !full ? S_HOLD : S_MARK;
				S_HOLD: state <= start ? S_HOLD : S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: src/pixel_fifo.sv
`timescale 1ns/1ps
`include "draw_params.svh"

module pixel_fifo (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push,
	input  draw_pkg::fifo_entry_t wr_entry,
	input  logic                  pop,
	output draw_pkg::fifo_entry_t rd_entry,
	output logic                  full,
	output logic                  empty
);

	localparam int DEPTH = `DRAW_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	draw_pkg::fifo_entry_t mem [DEPTH];
	logic [AW-1:0]         wr_ptr, rd_ptr;
	logic [AW:0]           count, count_next;
	logic                  do_push, do_pop;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign rd_entry = mem[rd_ptr];        // head of queue.

	always_comb begin
		count_next = count;
		if (do_push && !do_pop)
			count_next = count + 1'b1;
		else if (do_pop && !do_push)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count_next;
			full <= (count_next == (AW+1)'(DEPTH));
			empty <= (count_next == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wr_entry;
	end

endmodule

// File: src/framebuffer_writer.sv
`timescale 1ns/1ps
`include "draw_params.svh"

module framebuffer_writer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  clear,
	input  logic [`DRAW_C_W-1:0]  clear_colour,
	input  logic                  start,
	input  logic                  empty,
	input  draw_pkg::fifo_entry_t head,
	output logic                  pop,
	input  draw_pkg::rd_port_t    rd,
	output logic [`DRAW_C_W-1:0]  rd_colour,
	output logic                  done,
	output logic [17:0]           pixel_count,
	output logic                  clear_busy
);

	localparam int WORDS = `DRAW_SCREEN_W * `DRAW_SCREEN_H;
	localparam int AW = $clog2(WORDS);

	logic [`DRAW_C_W-1:0] mem [WORDS];
	logic [AW-1:0]        clear_addr, waddr;
	logic [`DRAW_C_W-1:0] clear_col, wdata;
	logic                 clear_wait;    // sweep over, clear not yet released.
	logic                 we;
	draw_pkg::pixel_t     head_pix;

	function automatic logic [AW-1:0] fb_addr(input logic [`DRAW_X_W-1:0] x,
											   input logic [`DRAW_Y_W-1:0] y);
		return AW'(y) * AW'(`DRAW_SCREEN_W) + AW'(x);
	endfunction

	function automatic logic on_screen(input logic [`DRAW_X_W-1:0] x,
									   input logic [`DRAW_Y_W-1:0] y);
		return (x < `DRAW_SCREEN_W) && (y < `DRAW_SCREEN_H);
	endfunction

	assign head_pix = head.payload.pixel;
	assign pop = !empty && !clear_busy;

	// single write port shared by sweep and pixel pops.
	always_comb begin
		we = clear_busy;
		waddr = clear_addr;
		wdata = clear_col;
		if (!clear_busy && pop && !head.is_marker && on_screen(head_pix.x, head_pix.y)) begin
			we = 1'b1;
			waddr = fb_addr(head_pix.x, head_pix.y);
			wdata = head_pix.colour;
		end
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rd_colour = on_screen(rd.x, rd.y) ? mem[fb_addr(rd.x, rd.y)] : '0;

	// ------------------------------------------------------------
	// clear sweep
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clear_busy <= 1'b0;
			clear_wait <= 1'b0;
			clear_addr <= '0;
		end else if (clear_busy) begin
			clear_addr <= clear_addr + 1'b1;
			if (clear_addr == AW'(WORDS - 1)) begin
				clear_busy <= 1'b0;
				clear_wait <= 1'b1;
			end
		end else if (clear_wait) begin
			clear_wait <= clear;
		end else if (clear) begin
			clear_busy <= 1'b1;
			clear_addr <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (clear && !clear_busy && !clear_wait)
			clear_col <= clear_colour;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
			pixel_count <= '0;
		end else if (!start) begin
			done <= 1'b0;
		end else if (pop && head.is_marker) begin
			done <= 1'b1;
			pixel_count <= head.payload.marker.count;  // same word, read as a count.
		end
	end

endmodule

// File: src/reuleaux_draw_top.sv
`timescale 1ns/1ps
`include "draw_params.svh"

module reuleaux_draw_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic [`DRAW_C_W-1:0] colour,
	input  draw_pkg::pixel_t     centre,
	input  logic [7:0]           diameter,
	input  logic                 clear,
	input  logic [`DRAW_C_W-1:0] clear_colour,
	input  draw_pkg::rd_port_t   rd,
	output logic [`DRAW_C_W-1:0] rd_colour,
	output logic                 done,
	output logic [17:0]          pixel_count,
	output logic                 clear_busy
);

	draw_pkg::fifo_entry_t wr_entry, head;
	logic                  push, pop, full, empty;

	reuleaux_producer u_producer (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.colour   (colour),
		.centre   (centre),
		.diameter (diameter),
		.full     (full),
		.push     (push),
		.entry    (wr_entry)
	);

	pixel_fifo u_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.push     (push),
		.wr_entry (wr_entry),
		.pop      (pop),
		.rd_entry (head),
		.full     (full),
		.empty    (empty)
	);

	framebuffer_writer u_writer (
		.clk          (clk),
		.rst_n        (rst_n),
		.clear        (clear),
		.clear_colour (clear_colour),
		.start        (start),
		.empty        (empty),
		.head         (head),
		.pop          (pop),
		.rd           (rd),
		.rd_colour    (rd_colour),
		.done         (done),
		.pixel_count  (pixel_count),
		.clear_busy   (clear_busy)
	);

endmodule

// File: bench/reuleaux_draw_assertions.sv
`timescale 1ns/1ps

module reuleaux_draw_assertions (
	input logic clk,
	input logic rst_n,
	input logic push,
	input logic full,
	input logic pop,
	input logic empty,
	input logic marker_pop,
	input logic done
);

	int fails = 0;                    // failed assertions of this instance.

	no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
	else begin
		fails++;
		$error("push while the FIFO is full");
	end

	no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
	else begin
		fails++;
		$error("pop while the FIFO is empty");
	end

	// the marker is the last entry of a shape, so done finds the FIFO drained.
	done_after_marker: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> $past(marker_pop) && empty)
	else begin
		fails++;
		$error("done rose without a marker pop or with entries left behind the marker");
	end

endmodule

// File: bench/reuleaux_draw_tb.sv
`timescale 1ns/1ps
`include "draw_params.svh"

module reuleaux_draw_tb;

	typedef struct packed {
		logic [7:0] cx;
		logic [6:0] cy;
		logic [7:0] d;
		logic [2:0] colour;
		logic [2:0] clr;
		logic [1:0] mode;             // 0 plain, 1 draw during clear, 2 abort then redraw.
	} case_t;

	localparam int NCASES = 3;

	logic               clk = 1'b0;
	logic               rst_n, start, clear, done, clear_busy;
	logic [2:0]         colour, clear_colour, rd_colour;
	logic [7:0]         diameter;
	logic [17:0]        pixel_count;
	draw_pkg::pixel_t   centre;
	draw_pkg::rd_port_t rd;
	case_t              cases [NCASES];
	int                 errors, checks, cycles, limit;
	integer             seed;

	reuleaux_draw_top UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.colour       (colour),
		.centre       (centre),
		.diameter     (diameter),
		.clear        (clear),
		.clear_colour (clear_colour),
		.rd           (rd),
		.rd_colour    (rd_colour),
		.done         (done),
		.pixel_count  (pixel_count),
		.clear_busy   (clear_busy)
	);

	bind pixel_fifo reuleaux_draw_assertions fifo_chk (
		.clk(clk), .rst_n(rst_n), .push(push), .full(full), .pop(pop), .empty(empty),
		.marker_pop(1'b0), .done(1'b0));
	bind framebuffer_writer reuleaux_draw_assertions wr_chk (
		.clk(clk), .rst_n(rst_n), .push(1'b0), .full(1'b0), .pop(1'b0), .empty(empty),
		.marker_pop(pop && head.is_marker), .done(done));

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, a clear or draw never finished", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// read port helpers
	// ------------------------------------------------------------
	task automatic read_px(input int x, input int y, output logic [2:0] c);
		@(posedge clk);
		rd.x <= 8'(x);
		rd.y <= 7'(y);
		@(negedge clk);
		c = rd_colour;
	endtask

	task automatic expect_px(input int x, input int y, input logic [2:0] exp,
			input string what);
		logic [2:0] c;
		read_px(x, y, c);
		checks++;
		if (c !== exp) begin
			errors++;
			$display("ERR %0t: %s at (%0d,%0d) reads %0d, expected %0d",
				$time, what, x, y, c, exp);
		end
	endtask

	function automatic logic in_square(input case_t c, input int x, input int y);
		return (x >= int'(c.cx) - int'(c.d)) && (x <= int'(c.cx) + int'(c.d)) &&
			(y >= int'(c.cy) - int'(c.d)) && (y <= int'(c.cy) + int'(c.d));
	endfunction

	task automatic probe_random(input case_t c, input logic outside);
		logic [31:0] r;
		int          x;
		int          y;
		for (int n = 0; n < 16; n++) begin
			r = $random(seed);
			x = int'(r[15:0] % `DRAW_SCREEN_W);
			y = int'(r[31:16] % `DRAW_SCREEN_H);
			if (!outside || !in_square(c, x, y))
				expect_px(x, y, c.clr, "background");
		end
	endtask

	// ------------------------------------------------------------
	// control sequences
	// ------------------------------------------------------------
	task automatic run_clear(input logic [2:0] k, input logic wait_end);
		@(posedge clk);
		clear <= 1'b1;
		clear_colour <= k;
		@(negedge clk);
		while (!clear_busy)
			@(negedge clk);
		@(posedge clk);
		clear <= 1'b0;                // colour is latched and the sweep keeps going.
		if (wait_end) begin
			@(negedge clk);
			while (clear_busy)
				@(negedge clk);
		end
	endtask

	task automatic abort_draw();
		@(posedge clk);
		start <= 1'b1;
		repeat (30)
			@(posedge clk);
		start <= 1'b0;                // still inside arc 1.
		repeat (40) begin
			@(negedge clk);
			if (done) begin
				errors++;
				$display("ERR %0t: done high after an aborted draw", $time);
			end
		end
	endtask

	task automatic check_shape(input case_t c);
		int         d, cx, cy, top_y, bot_y, left_x, right_x, hits;
		logic [2:0] px;
		d = int'(c.d);
		cx = int'(c.cx);
		cy = int'(c.cy);
		top_y = cy - d * 37 / 64;
		bot_y = cy + d * 37 / 128;
		left_x = cx - d / 2;
		right_x = cx + d / 2;
		expect_px(cx, top_y + d, c.colour, "arc 1 bottom point");
		expect_px(left_x + d, bot_y, c.colour, "arc 2 right point");
		expect_px(right_x - d, bot_y, c.colour, "arc 3 left point");
		expect_px(cx, cy, c.clr, "centre pixel");
		expect_px(cx - d - 1, cy, c.clr, "left of square");
		expect_px(cx + d + 1, cy, c.clr, "right of square");
		expect_px(cx, cy - d - 1, c.clr, "above square");
		expect_px(cx + d + 1, cy + d + 1, c.clr, "below right corner");
		probe_random(c, 1'b1);
		hits = 0;
		for (int x = cx - d; x <= cx + d; x++) begin
			for (int y = cy - d; y <= cy + d; y++) begin
				read_px(x, y, px);
				if (px == c.colour)
					hits++;
			end
		end
		checks++;
		if (pixel_count == 0 || hits > int'(pixel_count)) begin
			errors++;
			$display("ERR %0t: %0d coloured pixels against pixel_count %0d",
				$time, hits, pixel_count);
		end
		if (!done) begin
			errors++;
			$display("ERR %0t: done fell while start was held", $time);
		end
	endtask

	initial begin
		seed = 32'h1a72;
		errors = 0;
		checks = 0;
		cycles = 0;
		rst_n = 1'b0;
		start = 1'b0;
		clear = 1'b0;
		colour = '0;
		clear_colour = '0;
		diameter = '0;
		centre = '0;
		rd = '0;
		cases[0] = '{cx: 8'd80, cy: 7'd64, d: 8'd32, colour: 3'd5, clr: 3'd1, mode: 2'd0};
		cases[1] = '{cx: 8'd100, cy: 7'd58, d: 8'd24, colour: 3'd2, clr: 3'd6, mode: 2'd1};
		cases[2] = '{cx: 8'd70, cy: 7'd60, d: 8'd20, colour: 3'd7, clr: 3'd0, mode: 2'd2};
		limit = 0;
		foreach (cases[i])
			limit += 3 * (`DRAW_SCREEN_W * `DRAW_SCREEN_H + 8 * cases[i].d * 3);

		repeat (2)
			@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (done || clear_busy) begin
			errors++;
			$display("ERR %0t: done %0b clear_busy %0b after reset", $time, done, clear_busy);
		end

		for (int i = 0; i < NCASES; i++) begin
			@(posedge clk);
			centre.x <= cases[i].cx;
			centre.y <= cases[i].cy;
			centre.colour <= '0;
			diameter <= cases[i].d;
			colour <= cases[i].colour;
			run_clear(cases[i].clr, cases[i].mode != 2'd1);
			if (cases[i].mode == 2'd1)
				repeat (50)
					@(posedge clk);   // start lands in the middle of the sweep.
			else
				probe_random(cases[i], 1'b0);
			if (cases[i].mode == 2'd2)
				abort_draw();
			@(posedge clk);
			start <= 1'b1;
			@(negedge clk);
			while (!done)
				@(negedge clk);
			check_shape(cases[i]);
			@(posedge clk);
			start <= 1'b0;
			repeat (2)
				@(negedge clk);
			if (done) begin
				errors++;
				$display("ERR %0t: done still high after start fell", $time);
			end
		end

		errors += UUT.u_fifo.fifo_chk.fails + UUT.u_writer.wr_chk.fails;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
src/draw_pkg.sv
src/circle_engine.sv
src/reuleaux_producer.sv
src/pixel_fifo.sv
src/framebuffer_writer.sv
src/reuleaux_draw_top.sv
bench/reuleaux_draw_assertions.sv
bench/reuleaux_draw_tb.sv

// File: Bender.yml
package:
  name: reuleaux_draw

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/draw_pkg.sv
      - src/circle_engine.sv
      - src/reuleaux_producer.sv
      - src/pixel_fifo.sv
      - src/framebuffer_writer.sv
      - src/reuleaux_draw_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/reuleaux_draw_assertions.sv
      - bench/reuleaux_draw_tb.sv
